// File: verilog.f
verilog/riscv_isa_pkg.sv
verilog/core_bus_pkg.sv
verilog/rv_regfile.sv
verilog/rv_csr_file.sv
verilog/rv_execute.sv
verilog/rv64_core.sv
dv/tb_rv64_core.sv

// File: Makefile
# Verilator build and run of the RV64 core testbench

TOP       ?= tb_rv64_core
SIM_DIR   ?= sim_build
LOG       ?= sim.log
FILELIST  ?= verilog.f
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG  := SOME TESTS FAILED
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(SIM_DIR) -f $(FILELIST)

run: build
	$(SIM_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early, see $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(SIM_DIR) $(LOG)

// File: dv/tb_rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv64_core import riscv_isa_pkg::*, core_bus_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000;
    localparam logic [XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0100;  // imem word 64
    localparam logic [XLEN-1:0] RES_ADDR    = 64'h100;  // Result word of every program
    localparam logic [XLEN-1:0] MARK_ADDR   = 64'h104;  // Handler marker
    localparam logic [XLEN-1:0] LOAD_ADDR   = 64'h200;  // Random preload word
    localparam logic [ILEN-1:0] NOP         = 32'h0000_0013;  // ADDI x0, x0, 0
    localparam longint OP_A    = -1234;
    localparam longint OP_B    = 567;
    localparam int     NTEST   = 16;  // Table capacity
    localparam int     SLOTS   = 8;
    localparam int     TIMEOUT = 100;  // Cycles per wait

    logic              clk;
    logic              reset;
    logic [ILEN-1:0]   instr;
    logic [XLEN-1:0]   pc;
    logic [XLEN-1:0]   bus_addr;
    logic [BUS_DW-1:0] bus_wdata;
    logic              bus_we;
    logic              bus_re;
    logic [BUS_DW-1:0] bus_rdata = '0;
    logic              irq;
    logic              irq_ack;
    logic              heartbeat;
    logic              hb_prev;   // Heartbeat at the last sample
    bit                hb_valid;  // Out of reset over the last edge

    logic [ILEN-1:0]   imem [256];  // Mirrored every 1 KiB
    logic [BUS_DW-1:0] dmem [256];
    int                seed;
    int                errors, checks, ack_count;

    // Test table
    string             test_name [NTEST];
    logic [ILEN-1:0]   prog      [NTEST][SLOTS];
    longint            op_a      [NTEST];
    longint            op_b      [NTEST];
    logic [XLEN-1:0]   exp_addr  [NTEST];
    logic [BUS_DW-1:0] exp_data  [NTEST];
    int                ntest, nslot;

    rv64_core #(
        .RESET_PC    (RESET_PC),
        .MTVEC_RESET (MTVEC_RESET)
    ) i_rv64_core (
        .clk         (clk),
        .reset       (reset),
        .instr_i     (instr),
        .pc_o        (pc),
        .bus_addr_o  (bus_addr),
        .bus_wdata_o (bus_wdata),
        .bus_we_o    (bus_we),
        .bus_re_o    (bus_re),
        .bus_rdata_i (bus_rdata),
        .irq_i       (irq),
        .irq_ack_o   (irq_ack),
        .heartbeat_o (heartbeat)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    assign instr = imem[pc[9:2]];  // Word at pc, no wait state

    // Read data taken in the strobe cycle, held until the next read
    always @(negedge clk) begin
        if (bus_re) begin
            bus_rdata <= dmem[bus_addr[9:2]];
        end
    end

    // Instruction encoders, one per format
    function automatic logic [ILEN-1:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [ILEN-1:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [ILEN-1:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [ILEN-1:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [ILEN-1:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [ILEN-1:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [ILEN-1:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
            input logic [11:0] imm);
        return i_format(imm, rs1, F3_ADD, rd, OPC_OP_IMM);
    endfunction

    task automatic open_entry(input string nm, input longint a, input longint b);
        test_name[ntest] = nm;
        op_a[ntest]      = a;
        op_b[ntest]      = b;
        nslot            = 0;
        for (int k = 0; k < SLOTS; k++) begin
            prog[ntest][k] = NOP;
        end
    endtask

    task automatic append_word(input logic [ILEN-1:0] word);
        prog[ntest][nslot] = word;
        nslot++;
    endtask

    // Tail of every program, SW x3 to RES_ADDR then a self loop
    task automatic close_entry(input logic [BUS_DW-1:0] expected);
        append_word(s_format(RES_ADDR[11:0], 5'd3, 5'd0, F3_SW));
        append_word(j_format(21'd0, 5'd0));
        exp_addr[ntest] = RES_ADDR;
        exp_data[ntest] = expected;
        ntest++;
    endtask

    task automatic alu_entry(input string nm, input logic [ILEN-1:0] word,
            input logic [BUS_DW-1:0] expected);
        open_entry(nm, OP_A, OP_B);
        append_word(addi(5'd1, 5'd0, 12'(op_a[ntest])));  // x1 = a
        append_word(addi(5'd2, 5'd0, 12'(op_b[ntest])));  // x2 = b
        append_word(word);
        close_entry(expected);
    endtask

    task automatic build_table();
        alu_entry("add", r_format(7'd0, 5'd2, 5'd1, F3_ADD, 5'd3), 32'(OP_A + OP_B));
        alu_entry("sub", r_format(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd3), 32'(OP_A - OP_B));
        alu_entry("slt", r_format(7'd0, 5'd2, 5'd1, F3_SLT, 5'd3),
                  (OP_A < OP_B) ? 32'd1 : 32'd0);
        alu_entry("slt_rev", r_format(7'd0, 5'd1, 5'd2, F3_SLT, 5'd3),
                  (OP_B < OP_A) ? 32'd1 : 32'd0);
        alu_entry("slli", i_format(12'd9, 5'd1, F3_SLL, 5'd3, OPC_OP_IMM), 32'(OP_A << 9));
        alu_entry("srli", i_format(12'd36, 5'd1, F3_SRL, 5'd3, OPC_OP_IMM), 32'(OP_A >> 36));
        open_entry("lui", 0, 0);
        append_word(u_format(20'hABCDE, 5'd3, OPC_LUI));
        close_entry(32'hABCD_E000);
        open_entry("auipc", 0, 0);
        append_word(NOP);
        append_word(u_format(20'h12345, 5'd3, OPC_AUIPC));  // At RESET_PC + 4
        close_entry(32'(RESET_PC + 64'd4 + 64'h1234_5000));
        open_entry("beq", OP_A, OP_A);
        append_word(addi(5'd1, 5'd0, 12'(OP_A)));
        append_word(addi(5'd2, 5'd0, 12'(OP_A)));
        append_word(addi(5'd3, 5'd0, 12'd7));
        append_word(b_format(13'd8, 5'd2, 5'd1, F3_BEQ));  // Taken, skips next
        append_word(addi(5'd3, 5'd0, 12'd99));
        close_entry(32'd7);
        open_entry("jal", 0, 0);
        append_word(j_format(21'd8, 5'd3));  // Link into x3
        append_word(addi(5'd3, 5'd0, 12'd99));
        close_entry(32'(RESET_PC + 64'd4));
        open_entry("jalr", 0, 0);
        append_word(u_format(20'd0, 5'd1, OPC_AUIPC));  // x1 = RESET_PC
        append_word(addi(5'd3, 5'd0, 12'd5));
        append_word(i_format(12'd16, 5'd1, 3'b000, 5'd0, OPC_JALR));  // To slot 4
        append_word(addi(5'd3, 5'd0, 12'd99));
        close_entry(32'd5);
        open_entry("lw_sw", 0, 0);
        append_word(i_format(LOAD_ADDR[11:0], 5'd0, F3_LW, 5'd3, OPC_LOAD));
        close_entry(dmem[LOAD_ADDR[9:2]]);
        open_entry("x0_zero", OP_A, 0);
        append_word(i_format(LOAD_ADDR[11:0], 5'd0, F3_LW, 5'd0, OPC_LOAD));
        append_word(addi(5'd0, 5'd0, 12'(OP_A)));
        append_word(r_format(7'd0, 5'd0, 5'd0, F3_ADD, 5'd3));  // x3 = x0 + x0
        close_entry(32'd0);
    endtask

    // One cycle, sampled on the falling edge
    task automatic next_cycle();
        @(negedge clk);
        if (irq_ack) begin
            ack_count++;
        end
        if (reset && hb_valid && heartbeat === hb_prev) begin  // Flips on every edge
            $display("** Error heartbeat: expected %b, actual %b", ~hb_prev, heartbeat);
            errors++;
        end
        hb_prev  = heartbeat;
        hb_valid = reset;
    endtask

    task automatic apply_reset();
        reset = 1'b0;
        repeat (16) next_cycle();
        ack_count = 0;
        reset = 1'b1;
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
            input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", what, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_store(input string what, output logic [XLEN-1:0] addr,
            output logic [BUS_DW-1:0] data, output bit seen);
        int n;
        n    = 0;
        seen = 1'b0;
        addr = '0;
        data = '0;
        while (!seen && n < TIMEOUT) begin
            next_cycle();
            if (bus_we) begin
                seen = 1'b1;
                addr = bus_addr;
                data = bus_wdata;
            end
            n++;
        end
        if (!seen) begin
            $display("Timeout in %s: the core never wrote to the data bus", what);
            errors++;
        end
    endtask

    task automatic wait_ack(input int target, input string what);
        int n;
        n = 0;
        while (ack_count < target && n < TIMEOUT) begin
            next_cycle();
            n++;
        end
        if (ack_count < target) begin
            $display("Timeout in %s: the interrupt was never acknowledged", what);
            errors++;
        end
    endtask

    task automatic run_entry(input int t);
        logic [XLEN-1:0]   addr;
        logic [BUS_DW-1:0] data;
        bit                seen;
        for (int k = 0; k < 256; k++) begin
            imem[k] = (k < SLOTS) ? prog[t][k] : NOP;
        end
        apply_reset();
        wait_store(test_name[t], addr, data, seen);
        if (seen) begin
            check_value({test_name[t], " addr"}, exp_addr[t], addr);
            check_value({test_name[t], " data"}, 64'(exp_data[t]), 64'(data));
        end
    endtask

    // Counting loop, handler at MTVEC_RESET stores a marker and returns
    task automatic irq_test();
        logic [XLEN-1:0]   addr;
        logic [BUS_DW-1:0] data;
        bit                seen;
        for (int k = 0; k < 256; k++) begin
            imem[k] = NOP;
        end
        imem[0]  = addi(5'd3, 5'd0, 12'd0);
        imem[1]  = addi(5'd3, 5'd3, 12'd1);  // Loop counts in x3
        imem[2]  = s_format(RES_ADDR[11:0], 5'd3, 5'd0, F3_SW);
        imem[3]  = j_format(21'(-8), 5'd0);  // Back to slot 1
        imem[64] = addi(5'd5, 5'd0, 12'h055);
        imem[65] = s_format(MARK_ADDR[11:0], 5'd5, 5'd0, F3_SW);
        imem[66] = INSN_MRET;
        apply_reset();
        wait_store("irq loop", addr, data, seen);
        check_value("irq loop data", 64'd1, 64'(data));  // First pass stores 1
        irq = 1'b1;
        wait_ack(1, "irq entry");
        check_value("irq vector", MTVEC_RESET, pc);
        irq = 1'b0;
        next_cycle();
        check_value("irq ack width", 64'd0, 64'(irq_ack));
        irq = 1'b1;  // Second request held across the handler
        wait_store("irq handler", addr, data, seen);
        check_value("irq marker addr", MARK_ADDR, addr);
        check_value("irq marker data", 64'h55, 64'(data));
        check_value("irq masked acks", 64'd1, 64'(ack_count));
        wait_ack(2, "irq after mret");  // MIE back on after MRET
        irq = 1'b0;
        wait_store("irq handler again", addr, data, seen);
        check_value("irq marker again", MARK_ADDR, addr);
        wait_store("irq return", addr, data, seen);
        check_value("irq return addr", RES_ADDR, addr);
        check_value("irq return data", 64'd2, 64'(data));  // JAL then one more count
    endtask

    initial begin
        seed      = 32'hc27;
        reset     = 1'b0;
        irq       = 1'b0;
        hb_prev   = 1'b0;
        hb_valid  = 1'b0;
        errors    = 0;
        checks    = 0;
        ack_count = 0;
        ntest     = 0;
        for (int k = 0; k < 256; k++) begin
            dmem[k] = $random(seed);
            imem[k] = NOP;
        end
        build_table();
        for (int t = 0; t < ntest; t++) begin
            run_entry(t);
        end
        irq_test();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/rv64_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv64_core import riscv_isa_pkg::*, core_bus_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC    = 64'h0000_0000_8000_0000,
    parameter logic [XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [ILEN-1:0]   instr_i,
    output logic      [XLEN-1:0]   pc_o,
    output logic      [XLEN-1:0]   bus_addr_o,
    output logic      [BUS_DW-1:0] bus_wdata_o,
    output logic                   bus_we_o,
    output logic                   bus_re_o,
    input  wire logic [BUS_DW-1:0] bus_rdata_i,
    input  wire logic              irq_i,
    output logic                   irq_ack_o,
    output logic                   heartbeat_o
);

    bus_req_t        bus_req;
    trap_req_t       trap_req;
    logic [4:0]      rs1_addr, rs2_addr, rd_addr;
    logic [XLEN-1:0] rs1_data, rs2_data, rd_data;
    logic            rd_we;
    logic            mie_en;
    logic [XLEN-1:0] mtvec, mepc;

    // Bus request onto the pins
    assign bus_addr_o  = bus_req.addr;
    assign bus_wdata_o = bus_req.wdata;
    assign bus_we_o    = bus_req.we;
    assign bus_re_o    = bus_req.re;

    rv_execute #(
        .RESET_PC (RESET_PC)
    ) i_rv_execute (
        .clk         (clk),
        .reset       (reset),
        .instr_i     (instr_i),
        .pc_o        (pc_o),
        .bus_req_o   (bus_req),
        .bus_rdata_i (bus_rdata_i),
        .irq_i       (irq_i),
        .irq_ack_o   (irq_ack_o),
        .heartbeat_o (heartbeat_o),
        .rs1_addr_o  (rs1_addr),
        .rs2_addr_o  (rs2_addr),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .rd_we_o     (rd_we),
        .rd_addr_o   (rd_addr),
        .rd_data_o   (rd_data),
        .trap_o      (trap_req),
        .mie_en_i    (mie_en),
        .mtvec_i     (mtvec),
        .mepc_i      (mepc)
    );

    rv_regfile i_rv_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .we_i       (rd_we),
        .waddr_i    (rd_addr),
        .wdata_i    (rd_data)
    );

    rv_csr_file #(
        .MTVEC_RESET (MTVEC_RESET)
    ) i_rv_csr_file (
        .clk      (clk),
        .reset    (reset),
        .trap_i   (trap_req),
        .mie_en_o (mie_en),
        .mtvec_o  (mtvec),
        .mepc_o   (mepc)
    );

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv_execute import riscv_isa_pkg::*, core_bus_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  wire logic              clk,
    input  wire logic              reset,
    input  wire logic [ILEN-1:0]   instr_i,
    output logic      [XLEN-1:0]   pc_o,
    output bus_req_t               bus_req_o,
    input  wire logic [BUS_DW-1:0] bus_rdata_i,
    input  wire logic              irq_i,
    output logic                   irq_ack_o,
    output logic                   heartbeat_o,
    output logic      [4:0]        rs1_addr_o,
    output logic      [4:0]        rs2_addr_o,
    input  wire logic [XLEN-1:0]   rs1_data_i,
    input  wire logic [XLEN-1:0]   rs2_data_i,
    output logic                   rd_we_o,
    output logic      [4:0]        rd_addr_o,
    output logic      [XLEN-1:0]   rd_data_o,
    output trap_req_t              trap_o,
    input  wire logic              mie_en_i,
    input  wire logic [XLEN-1:0]   mtvec_i,
    input  wire logic [XLEN-1:0]   mepc_i
);

    localparam logic [ILEN-1:0] IR_RESET = 32'h0000_0001;  // Opcode decodes to nothing

    rv_insn_u        ir_q;
    logic [XLEN-1:0] pc_q, pc_d;
    logic [XLEN-1:0] ir_pc;  // Address of insn in IR
    logic            bubble_q, bubble_d;
    logic            load_step_q, load_step_d;  // Second LW visit
    bus_req_t        bus_req_d;
    logic            take_irq;
    logic            is_mret;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [5:0]      shamt;

    assign ir_pc = pc_q - XLEN'(4);  // Fetch runs one word ahead
    assign pc_o  = pc_q;

    // Immediates straight from the union views
    assign imm_i = {{(XLEN-12){ir_q.i.imm[11]}}, ir_q.i.imm};
    assign imm_s = {{(XLEN-12){ir_q.s.imm_11_5[6]}}, ir_q.s.imm_11_5, ir_q.s.imm_4_0};
    assign imm_b = {{(XLEN-13){ir_q.b.imm_12}}, ir_q.b.imm_12, ir_q.b.imm_11,
                    ir_q.b.imm_10_5, ir_q.b.imm_4_1, 1'b0};
    assign imm_u = {{(XLEN-32){ir_q.u.imm_31_12[19]}}, ir_q.u.imm_31_12, 12'b0};
    assign imm_j = {{(XLEN-21){ir_q.j.imm_20}}, ir_q.j.imm_20, ir_q.j.imm_19_12,
                    ir_q.j.imm_11, ir_q.j.imm_10_1, 1'b0};
    assign shamt = ir_q.i.imm[5:0];  // RV64 uses 6 bits

    assign rs1_addr_o = ir_q.r.rs1;
    assign rs2_addr_o = ir_q.r.rs2;
    assign rd_addr_o  = ir_q.r.rd;

    // Interrupt only on a real insn, so ir_pc is a valid return address
    assign take_irq = irq_i && mie_en_i && !bubble_q;

    assign trap_o.enter = take_irq;
    assign trap_o.mret  = is_mret;
    assign trap_o.epc   = ir_pc;

    always_comb begin
        pc_d        = pc_q + XLEN'(4);  // Default sequential fetch
        bubble_d    = 1'b0;
        load_step_d = load_step_q;
        bus_req_d   = '0;  // Strobes last one cycle
        rd_we_o     = 1'b0;
        rd_data_o   = '0;
        is_mret     = 1'b0;
        if (take_irq) begin
            pc_d        = mtvec_i;
            bubble_d    = 1'b1;
            load_step_d = 1'b0;  // Aborted LW restarts after MRET
        end else if (!bubble_q) begin
            case (ir_q.r.opcode)
                OPC_LUI: begin
                    rd_we_o   = 1'b1;
                    rd_data_o = imm_u;
                end
                OPC_AUIPC: begin
                    rd_we_o   = 1'b1;
                    rd_data_o = ir_pc + imm_u;
                end
                OPC_OP_IMM: begin
                    rd_we_o = 1'b1;
                    case (ir_q.i.funct3)
                        F3_ADD:  rd_data_o = rs1_data_i + imm_i;
                        F3_SLL:  rd_data_o = rs1_data_i << shamt;
                        F3_SRL:  rd_data_o = rs1_data_i >> shamt;  // SRAI not kept
                        default: rd_we_o = 1'b0;
                    endcase
                end
                OPC_OP: begin
                    rd_we_o = 1'b1;
                    if (ir_q.r.funct3 == F3_SLT) begin
                        rd_data_o = XLEN'($signed(rs1_data_i) < $signed(rs2_data_i));
                    end else if (ir_q.r.funct3 == F3_ADD && ir_q.r.funct7 == F7_SUB) begin
                        rd_data_o = rs1_data_i - rs2_data_i;
                    end else if (ir_q.r.funct3 == F3_ADD && ir_q.r.funct7 == 7'd0) begin
                        rd_data_o = rs1_data_i + rs2_data_i;
                    end else begin
                        rd_we_o = 1'b0;
                    end
                end
                OPC_LOAD: if (ir_q.i.funct3 == F3_LW) begin
                    if (!load_step_q) begin  // Visit 1 issues the read
                        bus_req_d.addr = rs1_data_i + imm_i;
                        bus_req_d.re   = 1'b1;
                        pc_d           = ir_pc;  // Refetch the LW
                        bubble_d       = 1'b1;
                        load_step_d    = 1'b1;
                    end else begin  // Visit 2 takes the word
                        rd_we_o     = 1'b1;
                        rd_data_o   = {{(XLEN-BUS_DW){bus_rdata_i[BUS_DW-1]}}, bus_rdata_i};
                        load_step_d = 1'b0;
                    end
                end
                OPC_STORE: if (ir_q.s.funct3 == F3_SW) begin
                    bus_req_d.addr  = rs1_data_i + imm_s;
                    bus_req_d.wdata = rs2_data_i[BUS_DW-1:0];
                    bus_req_d.we    = 1'b1;
                    pc_d            = pc_q;  // Hold, next insn refetched
                    bubble_d        = 1'b1;
                end
                OPC_JAL: begin
                    rd_we_o   = 1'b1;
                    rd_data_o = pc_q;  // Link = own address + 4
                    pc_d      = ir_pc + imm_j;
                    bubble_d  = 1'b1;
                end
                OPC_JALR: begin
                    rd_we_o   = 1'b1;
                    rd_data_o = pc_q;
                    pc_d      = (rs1_data_i + imm_i) & ~XLEN'(1);
                    bubble_d  = 1'b1;
                end
                OPC_BRANCH: begin
                    if (ir_q.b.funct3 == F3_BEQ && rs1_data_i == rs2_data_i) begin
                        pc_d     = ir_pc + imm_b;
                        bubble_d = 1'b1;
                    end
                end
                OPC_SYSTEM: if (ir_q.raw == INSN_MRET) begin
                    is_mret  = 1'b1;
                    pc_d     = mepc_i;
                    bubble_d = 1'b1;
                end
                default: ;  // Unknown opcodes retire as NOP
            endcase
        end
    end

    // Fetch stage, IR loads every edge
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir_q.raw    <= IR_RESET;
            heartbeat_o <= 1'b0;
        end else begin
            ir_q.raw    <= instr_i;
            heartbeat_o <= ~heartbeat_o;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q        <= RESET_PC;
            bubble_q    <= 1'b0;
            load_step_q <= 1'b0;
            bus_req_o   <= '0;
            irq_ack_o   <= 1'b0;
        end else begin
            pc_q        <= pc_d;
            bubble_q    <= bubble_d;
            load_step_q <= load_step_d;
            bus_req_o   <= bus_req_d;
            irq_ack_o   <= take_irq;  // Bubble after entry blocks a repeat
        end
    end

    a_bus_excl: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req_o.we && bus_req_o.re));

    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        irq_ack_o |=> !irq_ack_o);

endmodule

`default_nettype wire

// File: verilog/rv_csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module rv_csr_file import riscv_isa_pkg::*, core_bus_pkg::*; #(
    parameter logic [XLEN-1:0] MTVEC_RESET = 64'h0000_0000_8000_0100
) (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire trap_req_t       trap_i,
    output logic                 mie_en_o,
    output logic      [XLEN-1:0] mtvec_o,
    output logic      [XLEN-1:0] mepc_o
);

    logic [XLEN-1:0] mstatus_q;
    logic [XLEN-1:0] mepc_q;
    logic [XLEN-1:0] mcause_q;
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mstatus_rd;

    // Index based view of the machine CSRs
    function automatic logic [XLEN-1:0] csr_read(input logic [11:0] idx);
        case (idx)
            CSR_MSTATUS: return mstatus_q;
            CSR_MEPC:    return mepc_q;
            CSR_MCAUSE:  return mcause_q;
            CSR_MTVEC:   return mtvec_q;
            default:     return '0;  // Unimplemented reads as zero
        endcase
    endfunction

    always_comb begin
        mstatus_rd = csr_read(CSR_MSTATUS);
        mie_en_o   = mstatus_rd[MSTATUS_MIE];
        mtvec_o    = csr_read(CSR_MTVEC);
        mepc_o     = csr_read(CSR_MEPC);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q              <= '0;
            mstatus_q[MSTATUS_MIE] <= 1'b1;  // Interrupts enabled out of reset
            mepc_q                 <= '0;
            mcause_q               <= '0;
            mtvec_q                <= MTVEC_RESET;  // Fixed handler base
        end else if (trap_i.enter) begin
            mepc_q                  <= trap_i.epc;
            mcause_q                <= MCAUSE_M_EXT_IRQ;
            mstatus_q[MSTATUS_MPIE] <= mstatus_q[MSTATUS_MIE];  // Stack MIE
            mstatus_q[MSTATUS_MIE]  <= 1'b0;  // No nesting
        end else if (trap_i.mret) begin
            mstatus_q[MSTATUS_MIE]  <= mstatus_q[MSTATUS_MPIE];  // Unstack
            mstatus_q[MSTATUS_MPIE] <= 1'b1;
        end
    end

    // Execute gives interrupt priority over the insn, so MRET is dropped
    a_trap_excl: assert property (@(posedge clk) disable iff (!reset)
        !(trap_i.enter && trap_i.mret));

endmodule

`default_nettype wire

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv_regfile import riscv_isa_pkg::*; (
    input  wire logic            clk,
    input  wire logic            reset,
    input  wire logic [4:0]      rs1_addr_i,
    input  wire logic [4:0]      rs2_addr_i,
    output logic      [XLEN-1:0] rs1_data_o,
    output logic      [XLEN-1:0] rs2_data_o,
    input  wire logic            we_i,
    input  wire logic [4:0]      waddr_i,
    input  wire logic [XLEN-1:0] wdata_i
);

    logic [XLEN-1:0] regs [32];

    // Combinational read ports
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int k = 0; k < 32; k++) begin
                regs[k] <= '0;  // Whole file cleared
            end
        end else if (we_i && (waddr_i != 5'd0)) begin  // x0 stays zero
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 hardwired, whatever execute sends on the write port
    a_x0_zero: assert property (@(posedge clk) disable iff (!reset)
        regs[0] == '0);

endmodule

`default_nettype wire

// File: verilog/core_bus_pkg.sv
`default_nettype none

package core_bus_pkg;

    import riscv_isa_pkg::*;

    localparam int BUS_DW = 32;  // Data lane, one word per transfer

    // Registered data bus request, split onto pins at the top
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic [BUS_DW-1:0] wdata;
        logic              we;  // One-cycle write strobe
        logic              re;  // One-cycle read strobe
    } bus_req_t;

    // Execute to CSR block, one cycle per event
    typedef struct packed {
        logic            enter;  // Interrupt taken
        logic            mret;   // Return from handler
        logic [XLEN-1:0] epc;    // Address of discarded insn
    } trap_req_t;

endpackage

`default_nettype wire

// File: verilog/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    localparam int XLEN = 64;  // Integer register width
    localparam int ILEN = 32;  // Instruction width

    // Major opcodes, bits [6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;  // ADDI SLLI SRLI
    localparam logic [6:0] OPC_OP     = 7'b0110011;  // ADD SUB SLT
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // Only MRET decoded

    localparam logic [2:0] F3_ADD = 3'b000;  // Also ADDI and SUB
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    localparam logic [ILEN-1:0] INSN_MRET = 32'h3020_0073;

    // Machine CSR indices
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    localparam int MSTATUS_MIE  = 3;  // Global machine interrupt enable
    localparam int MSTATUS_MPIE = 7;  // MIE before trap entry

    // Interrupt flag in MSB, cause 11 = machine external
    localparam logic [XLEN-1:0] MCAUSE_M_EXT_IRQ = {1'b1, 63'd11};

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_r_t;

    typedef struct packed {
        logic [11:0] imm;  // imm[11:0], shamt in low 6 bits
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } rv_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } rv_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } rv_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_j_t;

    // One IR word, read through every format at once
    typedef union packed {
        logic [ILEN-1:0] raw;
        rv_r_t r;
        rv_i_t i;
        rv_s_t s;
        rv_b_t b;
        rv_u_t u;
        rv_j_t j;
    } rv_insn_u;

endpackage

`default_nettype wire
